// ==== files.f ====
+incdir+sim
hdl/mips_pkg.sv
hdl/mips_alu.sv
hdl/reg_file.sv
hdl/div_unit.sv
hdl/avalon_ram.sv
hdl/mips_core.sv
hdl/cpu_system.sv
sim/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: mips_avalon_core

sources:
  - files:
      - hdl/mips_pkg.sv
      - hdl/mips_alu.sv
      - hdl/reg_file.sv
      - hdl/div_unit.sv
      - hdl/avalon_ram.sv
      - hdl/mips_core.sv
      - hdl/cpu_system.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/cpu_tb.sv

// ==== sim/tb_programs.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// kinds of expected result.
localparam int KIND_DIV_LO  = 0;
localparam int KIND_DIV_HI  = 1;
localparam int KIND_DIVU_LO = 2;
localparam int KIND_DIVU_HI = 3;
localparam int KIND_MEM     = 4;
localparam int KIND_LOOP    = 5;

localparam word_t PROG_BASE = 32'd4;

function automatic word_t r_type(input logic [5:0] fn, input reg_idx_t rs, input reg_idx_t rt,
                                 input reg_idx_t rd, input shamt_t sh);
    return {OP_SPECIAL, rs, rt, rd, sh, fn};
endfunction

function automatic word_t i_type(input logic [5:0] op, input reg_idx_t rs, input reg_idx_t rt,
                                 input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

task automatic new_program();
    prog_len = 0;
    data_en  = 1'b0;
endtask

task automatic emit(input word_t instr);
    prog[prog_len] = instr;
    prog_len++;
endtask

task automatic load_const(input reg_idx_t r, input word_t value);
    emit(i_type(OP_LUI, 0, r, value[31:16]));
    emit(i_type(OP_ORI, r, r, value[15:0]));
endtask

// jr $0 with a nop in the delay slot.
task automatic halt_tail();
    emit(r_type(FN_JR, 0, 0, 0, 0));
    emit(32'h0000_0000);
endtask

task automatic divide_tail(input logic [5:0] fn, input logic take_hi);
    emit(r_type(fn, 8, 9, 0, 0));
    emit(r_type(take_hi ? FN_MFHI : FN_MFLO, 0, 0, 2, 0));
    halt_tail();
endtask

task automatic divide_program(input logic [5:0] fn, input word_t x, input word_t y,
                              input logic take_hi);
    new_program();
    load_const(8, x);
    load_const(9, y);
    divide_tail(fn, take_hi);
endtask

// dividend is fff01234 << 3, divisor is -37.
task automatic sample_divide_program(input logic take_hi);
    new_program();
    emit(i_type(OP_LUI, 0, 8, 16'hfff0));
    emit(i_type(OP_ORI, 8, 8, 16'h1234));
    emit(r_type(FN_SLL, 0, 8, 8, 5'd3));
    emit(i_type(OP_ADDIU, 0, 9, 16'hffdb));
    divide_tail(FN_DIV, take_hi);
endtask

task automatic memory_program(input word_t a, input word_t b, input word_t k);
    new_program();
    load_const(8, a);
    load_const(9, b);
    emit(r_type(FN_ADDU, 8, 9, 2, 0));
    emit(r_type(FN_SUBU, 8, 9, 11, 0));
    emit(r_type(FN_AND, 8, 9, 12, 0));
    emit(r_type(FN_OR, 11, 12, 13, 0));
    emit(r_type(FN_SLT, 8, 9, 14, 0));
    emit(r_type(FN_SLTU, 8, 9, 15, 0));
    emit(r_type(FN_SRA, 0, 8, 16, 5'd5));
    emit(r_type(FN_ADDU, 2, 13, 2, 0));
    emit(r_type(FN_SUBU, 2, 16, 2, 0));
    emit(r_type(FN_ADDU, 2, 14, 2, 0));
    emit(r_type(FN_SLL, 0, 15, 14, 5'd1));
    emit(r_type(FN_ADDU, 2, 14, 2, 0));
    // store, clear v0, reload through another base.
    emit(i_type(OP_SW, 0, 2, 16'h0200));
    emit(i_type(OP_ADDIU, 0, 2, 16'h0000));
    emit(i_type(OP_ADDIU, 0, 17, 16'h01f0));
    emit(i_type(OP_LW, 17, 2, 16'h0010));
    emit(i_type(OP_LW, 0, 24, 16'h0204));
    emit(r_type(FN_ADDU, 2, 24, 2, 0));
    halt_tail();
    data_en   = 1'b1;
    data_addr = 32'h0000_0204;
    data_val  = k;
endtask

// bne jumps back two words, the step add sits in the delay slot.
task automatic loop_program(input logic [15:0] n, input logic [15:0] step);
    new_program();
    emit(i_type(OP_ADDIU, 0, 8, n));
    emit(i_type(OP_ADDIU, 0, 2, 16'h0000));
    emit(i_type(OP_ADDIU, 8, 8, 16'hffff));
    emit(i_type(OP_BNE, 8, 0, 16'hfffe));
    emit(i_type(OP_ADDIU, 2, 2, step));
    halt_tail();
endtask

function automatic word_t expected_v0(input int kind, input word_t x, input word_t y,
                                      input word_t z);
    word_t v;
    word_t q;
    word_t r;
    word_t sh;
    int    i;
    v = '0;
    case (kind)
        KIND_DIV_LO, KIND_DIV_HI: begin
            if (y == '0) begin
                q = '1;
                r = x;
            end else begin
                q = $signed(x) / $signed(y);
                r = $signed(x) % $signed(y);
            end
            v = (kind == KIND_DIV_HI) ? r : q;
        end
        KIND_DIVU_LO, KIND_DIVU_HI: begin
            if (y == '0) begin
                q = '1;
                r = x;
            end else begin
                q = x / y;
                r = x % y;
            end
            v = (kind == KIND_DIVU_HI) ? r : q;
        end
        KIND_MEM: begin
            sh = $signed(x) >>> 5;
            v  = x + y;
            v  = v + ((x - y) | (x & y));
            v  = v - sh;
            if ($signed(x) < $signed(y)) begin
                v = v + 32'd1;
            end
            if (x < y) begin
                v = v + 32'd2;
            end
            v = v + z;
        end
        KIND_LOOP: begin
            for (i = 0; i < x; i++) begin
                v = v + {{16{y[15]}}, y[15:0]};
            end
        end
        default: v = '0;
    endcase
    return v;
endfunction

`endif

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb;
    import mips_pkg::*;

    localparam int  RUNS       = 26;
    localparam int  RUN_CYCLES = 400;
    localparam time PERIOD     = 100;

    logic   clk;
    logic   rst;
    logic   load_en;
    word_t  load_addr;
    word_t  load_data;
    logic   active;
    word_t  register_v0;

    word_t  prog [64];
    int     prog_len;
    logic   data_en;
    word_t  data_addr;
    word_t  data_val;

    integer seed;
    int     test_num;
    string  test_name;
    word_t  expected;
    int     run_errors;
    int     pass_count;
    int     fail_count;
    event   halted;

    `include "tb_programs.svh"

    cpu_system UUT (
        .clk         (clk),
        .rst         (rst),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .active      (active),
        .register_v0 (register_v0)
    );

    always #(PERIOD / 2) clk = ~clk;

    // budget of 400 cycles for each program run.
    initial begin
        #(RUNS * RUN_CYCLES * PERIOD);
        $display("a program never halted, run stopped at %0t", $time);
        $display("TEST FAIL");
        $finish;
    end

    always @(halted) begin
        if (register_v0 !== expected) begin
            $display("ERROR at %0t: register_v0 = %h, expected %h", $time, register_v0, expected);
            run_errors++;
        end
        if (run_errors == 0) begin
            pass_count++;
            $display("test %0d %s: ok", test_num, test_name);
        end else begin
            fail_count++;
            $display("test %0d %s: failed", test_num, test_name);
        end
    end

    task automatic reset_cycle();
        @(negedge clk);
        if (active !== 1'b0) begin
            $display("ERROR at %0t: active = %b during reset, expected 0", $time, active);
            run_errors++;
        end
    endtask

    task automatic run_program(input string name, input word_t exp_v0);
        int i;
        test_num++;
        test_name  = name;
        expected   = exp_v0;
        run_errors = 0;
        rst        = 1'b1;
        // load while the core sits in reset.
        for (i = 0; i < prog_len; i++) begin
            reset_cycle();
            load_en   = 1'b1;
            load_addr = PROG_BASE + 4 * i;
            load_data = prog[i];
        end
        if (data_en) begin
            reset_cycle();
            load_en   = 1'b1;
            load_addr = data_addr;
            load_data = data_val;
        end
        for (i = 0; i < 5; i++) begin
            reset_cycle();
            load_en = 1'b0;
        end
        rst = 1'b0;
        @(negedge clk);
        if (active !== 1'b1) begin
            $display("ERROR at %0t: active = %b after reset, expected 1", $time, active);
            run_errors++;
        end
        while (active === 1'b1) begin
            @(negedge clk);
        end
        -> halted;
        @(negedge clk);
    endtask

    initial begin
        word_t       x;
        word_t       y;
        word_t       k;
        word_t       n;
        logic [15:0] step;
        logic        take_hi;
        int          i;
        clk        = 1'b0;
        rst        = 1'b1;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        seed       = 32'h896a;
        test_num   = 0;
        pass_count = 0;
        fail_count = 0;

        x = 32'hfff0_1234 << 3;
        y = 32'hffff_ffdb;
        sample_divide_program(1'b0);
        run_program("div quotient", expected_v0(KIND_DIV_LO, x, y, '0));
        sample_divide_program(1'b1);
        run_program("div remainder", expected_v0(KIND_DIV_HI, x, y, '0));

        for (i = 0; i < 20; i++) begin
            x = $random(seed);
            y = $random(seed);
            if (i % 4 == 0) begin
                x[31] = 1'b1;
            end
            // small divisors as well.
            if (i % 3 == 0) begin
                y = y >> 20;
            end
            take_hi = (i % 2 == 1);
            divide_program(FN_DIVU, x, y, take_hi);
            run_program("divu random",
                        expected_v0(take_hi ? KIND_DIVU_HI : KIND_DIVU_LO, x, y, '0));
        end

        x = $random(seed);
        // negative dividend so the signed quotient would be negated.
        x[31] = 1'b1;
        divide_program(FN_DIV, x, '0, 1'b0);
        run_program("div by zero lo", expected_v0(KIND_DIV_LO, x, '0, '0));
        divide_program(FN_DIVU, x, '0, 1'b1);
        run_program("divu by zero hi", expected_v0(KIND_DIVU_HI, x, '0, '0));

        x = $random(seed);
        y = $random(seed);
        k = $random(seed);
        memory_program(x, y, k);
        run_program("memory checksum", expected_v0(KIND_MEM, x, y, k));

        x    = $random(seed);
        n    = {29'd0, x[2:0]} + 32'd3;
        x    = $random(seed);
        step = x[15:0];
        loop_program(n[15:0], step);
        run_program("bne loop", expected_v0(KIND_LOOP, n, {16'd0, step}, '0));

        $display("tests run %0d, passed %0d, failed %0d", test_num, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== hdl/cpu_system.sv ====
`timescale 1ns/1ns

module cpu_system #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'd4,
    parameter int              MEM_WORDS    = 256
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            load_en,
    input  mips_pkg::word_t load_addr,
    input  mips_pkg::word_t load_data,
    output logic            active,
    output mips_pkg::word_t register_v0
);
    import mips_pkg::*;

    bus_req_t bus_req;
    bus_rsp_t bus_rsp;

    mips_core #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_core (
        .clk         (clk),
        .rst         (rst),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .active      (active),
        .register_v0 (register_v0)
    );

    // program and data share one memory.
    avalon_ram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_ram (
        .clk       (clk),
        .rst       (rst),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// ==== hdl/mips_core.sv ====
`timescale 1ns/1ns

module mips_core #(
    parameter mips_pkg::word_t RESET_VECTOR = 32'd4
) (
    input  logic               clk,
    input  logic               rst,
    output mips_pkg::bus_req_t bus_req,
    input  mips_pkg::bus_rsp_t bus_rsp,
    output logic               active,
    output mips_pkg::word_t    register_v0
);
    import mips_pkg::*;

    typedef enum logic [2:0] {FETCH, EXECUTE, MEM, DIV_WAIT, HALT} state_t;

    state_t   state;
    word_t    pc;
    word_t    ir;
    word_t    br_target;
    logic     br_pending;
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    shamt_t   shamt;
    word_t    imm_ext;
    word_t    data_a;
    word_t    data_b;
    word_t    alu_b;
    word_t    alu_result;
    logic     alu_zero;
    alu_op_t  alu_op;
    logic     use_imm;
    logic     zero_ext;
    logic     wb_en;
    logic     wb_rd;
    logic     is_lw;
    logic     is_sw;
    logic     is_div;
    logic     is_beq;
    logic     is_bne;
    logic     is_jr;
    logic     is_mfhi;
    logic     is_mflo;
    logic     wr_en;
    reg_idx_t wr_idx;
    word_t    wr_data;
    logic     fetch_done;
    logic     take_branch;
    logic     instr_done;
    logic     halting;
    div_req_t div_req;
    div_res_t div_res;

    assign opcode  = ir[31:26];
    assign rs      = ir[25:21];
    assign rt      = ir[20:16];
    assign rd      = ir[15:11];
    assign shamt   = ir[10:6];
    assign funct   = ir[5:0];
    assign imm_ext = zero_ext ? {16'd0, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
    assign alu_b   = use_imm ? imm_ext : data_b;

    always_comb begin
        alu_op   = ALU_ADD;
        use_imm  = 1'b1;
        zero_ext = 1'b0;
        wb_en    = 1'b0;
        wb_rd    = 1'b0;
        is_lw    = 1'b0;
        is_sw    = 1'b0;
        is_div   = 1'b0;
        is_beq   = 1'b0;
        is_bne   = 1'b0;
        is_jr    = 1'b0;
        is_mfhi  = 1'b0;
        is_mflo  = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                use_imm = 1'b0;
                wb_rd   = 1'b1;
                wb_en   = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    FN_MFHI: is_mfhi = 1'b1;
                    FN_MFLO: is_mflo = 1'b1;
                    FN_JR: begin
                        is_jr = 1'b1;
                        wb_en = 1'b0;
                    end
                    FN_DIV, FN_DIVU: begin
                        is_div = 1'b1;
                        wb_en  = 1'b0;
                    end
                    default: wb_en = 1'b0;
                endcase
            end
            OP_ADDIU: wb_en = 1'b1;
            OP_ORI: begin
                alu_op   = ALU_OR;
                zero_ext = 1'b1;
                wb_en    = 1'b1;
            end
            OP_LUI: begin
                alu_op = ALU_LUI;
                wb_en  = 1'b1;
            end
            OP_LW: is_lw = 1'b1;
            OP_SW: is_sw = 1'b1;
            OP_BEQ: begin
                alu_op  = ALU_SUB;
                use_imm = 1'b0;
                is_beq  = 1'b1;
            end
            OP_BNE: begin
                alu_op  = ALU_SUB;
                use_imm = 1'b0;
                is_bne  = 1'b1;
            end
            default: ;
        endcase
    end

    // writeback from execute, or from the lw data phase.
    assign wr_en   = (state == EXECUTE && wb_en)
                   || (state == MEM && is_lw && !bus_rsp.waitrequest);
    assign wr_idx  = wb_rd ? rd : rt;
    assign wr_data = is_lw ? bus_rsp.readdata
                   : is_mfhi ? div_res.hi
                   : is_mflo ? div_res.lo
                   : alu_result;

    // fetch waits for active, so nothing goes out on the bus in reset.
    assign bus_req.address   = (state == MEM) ? alu_result : pc;
    assign bus_req.read      = (state == FETCH && active) || (state == MEM && is_lw);
    assign bus_req.write     = (state == MEM) && is_sw;
    assign bus_req.writedata = data_b;

    assign div_req.start     = (state == EXECUTE) && is_div;
    assign div_req.signed_op = (funct == FN_DIV);
    assign div_req.dividend  = data_a;
    assign div_req.divisor   = data_b;

    assign fetch_done  = (state == FETCH) && bus_req.read && !bus_rsp.waitrequest;
    assign take_branch = is_jr || (is_beq && alu_zero) || (is_bne && !alu_zero);
    assign instr_done  = (state == EXECUTE && !(is_lw || is_sw || is_div))
                       || (state == MEM && !bus_rsp.waitrequest)
                       || (state == DIV_WAIT && div_res.done);
    // a jump to 0 stops the core once its delay slot has run.
    assign halting     = instr_done && br_pending && br_target == '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= FETCH;
            pc         <= RESET_VECTOR;
            br_pending <= 1'b0;
            active     <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (fetch_done) begin
                        state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    if (is_lw || is_sw) begin
                        state <= MEM;
                    end else if (is_div) begin
                        state <= DIV_WAIT;
                    end
                end
                default: ;
            endcase
            if (instr_done) begin
                state <= halting ? HALT : FETCH;
                if (br_pending) begin
                    pc         <= br_target;
                    br_pending <= 1'b0;
                end else begin
                    pc         <= pc + 32'd4;
                    br_pending <= take_branch;
                end
            end
            if (halting) begin
                active <= 1'b0;
            end else if (state != HALT) begin
                active <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            ir <= bus_rsp.readdata;
        end
        // branch offset counts from the delay slot.
        if (state == EXECUTE && take_branch) begin
            br_target <= is_jr ? data_a : pc + 32'd4 + {imm_ext[29:0], 2'b00};
        end
    end

    reg_file u_regs (
        .clk     (clk),
        .rst     (rst),
        .rd_a    (rs),
        .rd_b    (rt),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (wr_data),
        .data_a  (data_a),
        .data_b  (data_b),
        .v0      (register_v0)
    );

    mips_alu u_alu (
        .op     (alu_op),
        .a      (data_a),
        .b      (alu_b),
        .shamt  (shamt),
        .result (alu_result),
        .zero   (alu_zero)
    );

    div_unit u_div (
        .clk (clk),
        .rst (rst),
        .req (div_req),
        .res (div_res)
    );

endmodule

// ==== hdl/avalon_ram.sv ====
`timescale 1ns/1ns

module avalon_ram #(
    parameter int MEM_WORDS = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::bus_req_t bus_req,
    output mips_pkg::bus_rsp_t bus_rsp,
    input  logic               load_en,
    input  mips_pkg::word_t    load_addr,
    input  mips_pkg::word_t    load_data
);
    import mips_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    word_t         mem [MEM_WORDS];
    word_t         rdata;
    logic          rd_ready;
    logic [AW-1:0] bus_idx;
    logic [AW-1:0] load_idx;

    // byte addresses, word granularity.
    assign bus_idx  = bus_req.address[AW+1:2];
    assign load_idx = load_addr[AW+1:2];

    // one wait state per read.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ready <= 1'b0;
        end else begin
            rd_ready <= bus_req.read && !rd_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_idx] <= load_data;
        end else if (bus_req.write) begin
            mem[bus_idx] <= bus_req.writedata;
        end
        if (bus_req.read && !rd_ready) begin
            rdata <= mem[bus_idx];
        end
    end

    assign bus_rsp.readdata    = rdata;
    assign bus_rsp.waitrequest = bus_req.read && !rd_ready;

endmodule

// ==== hdl/div_unit.sv ====
`timescale 1ns/1ns

module div_unit (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::div_req_t req,
    output mips_pkg::div_res_t res
);
    import mips_pkg::*;

    logic        busy;
    logic [4:0]  count;
    logic        done;
    word_t       rem;
    word_t       quo;
    word_t       dvs;
    word_t       hi;
    word_t       lo;
    logic        neg_q;
    logic        neg_r;
    logic        div_zero;
    logic [32:0] shifted;
    logic [32:0] diff;
    word_t       rem_next;
    word_t       quo_next;

    // one restoring step, quotient bits shift in from the right.
    always_comb begin
        shifted = {rem, quo[31]};
        diff    = shifted - {1'b0, dvs};
        if (diff[32]) begin
            rem_next = shifted[31:0];
            quo_next = {quo[30:0], 1'b0};
        end else begin
            rem_next = diff[31:0];
            quo_next = {quo[30:0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= busy && count == 5'd31;
            if (req.start) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 5'd1;
                if (count == 5'd31) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.start) begin
            rem      <= '0;
            quo      <= (req.signed_op && req.dividend[31]) ? -req.dividend : req.dividend;
            dvs      <= (req.signed_op && req.divisor[31]) ? -req.divisor : req.divisor;
            neg_q    <= req.signed_op && (req.dividend[31] ^ req.divisor[31]);
            neg_r    <= req.signed_op && req.dividend[31];
            div_zero <= (req.divisor == '0);
        end else if (busy) begin
            rem <= rem_next;
            quo <= quo_next;
            // last step also applies the signs.
            if (count == 5'd31) begin
                hi <= neg_r ? -rem_next : rem_next;
                lo <= div_zero ? '1 : (neg_q ? -quo_next : quo_next);
            end
        end
    end

    assign res.done = done;
    assign res.hi   = hi;
    assign res.lo   = lo;

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::reg_idx_t rd_a,
    input  mips_pkg::reg_idx_t rd_b,
    input  logic               wr_en,
    input  mips_pkg::reg_idx_t wr_idx,
    input  mips_pkg::word_t    wr_data,
    output mips_pkg::word_t    data_a,
    output mips_pkg::word_t    data_b,
    output mips_pkg::word_t    v0
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // r0 is hardwired.
    assign data_a = (rd_a == '0) ? '0 : regs[rd_a];
    assign data_b = (rd_b == '0) ? '0 : regs[rd_b];

    assign v0 = regs[2];

endmodule

// ==== hdl/mips_alu.sv ====
`timescale 1ns/1ns

module mips_alu (
    input  mips_pkg::alu_op_t op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  mips_pkg::shamt_t  shamt,
    output mips_pkg::word_t   result,
    output logic              zero
);
    import mips_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: begin
                result = {31'd0, $signed(a) < $signed(b)};
            end
            ALU_SLTU: begin
                result = {31'd0, a < b};
            end
            // shifts take the rt operand on b.
            ALU_SLL: result = b << shamt;
            ALU_SRL: result = b >> shamt;
            ALU_SRA: result = $signed(b) >>> shamt;
            ALU_LUI: result = {b[15:0], 16'd0};
            default: result = a + b;
        endcase
    end

    // equality test for beq and bne.
    assign zero = (result == '0);

endmodule

// ==== hdl/mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [3:0]  alu_op_t;

    // alu function select.
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_SLT  = 4'd4;
    localparam alu_op_t ALU_SLTU = 4'd5;
    localparam alu_op_t ALU_SLL  = 4'd6;
    localparam alu_op_t ALU_SRL  = 4'd7;
    localparam alu_op_t ALU_SRA  = 4'd8;
    localparam alu_op_t ALU_LUI  = 4'd9;

    // primary opcodes.
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct field of SPECIAL.
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_MFHI = 6'h10;
    localparam logic [5:0] FN_MFLO = 6'h12;
    localparam logic [5:0] FN_DIV  = 6'h1a;
    localparam logic [5:0] FN_DIVU = 6'h1b;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef struct packed {
        word_t address;
        logic  read;
        logic  write;
        word_t writedata;
    } bus_req_t;

    typedef struct packed {
        word_t readdata;
        logic  waitrequest;
    } bus_rsp_t;

    typedef struct packed {
        logic  start;
        logic  signed_op;
        word_t dividend;
        word_t divisor;
    } div_req_t;

    typedef struct packed {
        logic  done;
        word_t hi;
        word_t lo;
    } div_res_t;

endpackage
